/* csr_unit.f */
+incdir+src
src/csr_pkg.sv
src/csr_access_check.sv
src/csr_regfile.sv
src/trap_control.sv
src/csr_unit_top.sv
verification/csr_unit_tb.sv

/* src/csr_access_check.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_access_check
    import csr_pkg::*;
(
    input  csr_cmd_e                cmd_i,
    input  logic [`CSR_ADDR_W-1:0]  addr_i,
    input  logic [`CSR_XLEN-1:0]    operand_i,
    input  logic [`CSR_XLEN-1:0]    rdata_i,
    input  priv_mode_e              mode_i,
    output logic                    illegal_o,
    output logic [`CSR_XLEN-1:0]    wdata_o
);

    logic cmd_is_csr;
    logic priv_fail;
    logic read_only;

    assign cmd_is_csr = (cmd_i == CMD_W) || (cmd_i == CMD_S) || (cmd_i == CMD_C);

    // Address bits 9:8 give the lowest mode allowed to touch the CSR
    assign priv_fail = addr_i[9:8] > mode_i;

    // Bits 11:10 == 2'b11 marks the read-only space
    assign read_only = addr_i[11:10] == 2'b11;

    // Every W/S/C is treated as a write, even with a zero operand
    always_comb begin
        illegal_o = 1'b0;
        if (cmd_is_csr) begin
            illegal_o = priv_fail || read_only;
        end else if (cmd_i == CMD_MRET) begin
            illegal_o = mode_i != PRIV_M;
        end
    end

    always_comb begin
        case (cmd_i)
            CMD_W:   wdata_o = operand_i;
            CMD_S:   wdata_o = rdata_i | operand_i;
            CMD_C:   wdata_o = rdata_i & ~operand_i;
            default: wdata_o = '0;
        endcase
    end

    // No request must never look like a faulting instruction
    a_none_is_legal: assert final (cmd_i != CMD_NONE || !illegal_o)
        else $error("illegal flag raised without a command");

endmodule

/* src/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Datapath and address widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12
`define CSR_TIME_W  64

// Exception cause codes
`define CAUSE_ILLEGAL_INSTR 2
`define CAUSE_ECALL_U       8
`define CAUSE_ECALL_M       11

// Interrupt codes, also the bit positions in mie and mip
`define IRQ_MSI 3
`define IRQ_MTI 7
`define IRQ_MEI 11

// misa layout
//   MXL = 1 (RV32) in bits 31:30
//   I = bit 8, M = bit 12, U = bit 20
`define MISA_VALUE 32'h4010_1100

`endif

/* src/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        ADDR_MSTATUS   = 12'h300,
        ADDR_MISA      = 12'h301,
        ADDR_MIE       = 12'h304,
        ADDR_MTVEC     = 12'h305,
        ADDR_MSCRATCH  = 12'h340,
        ADDR_MEPC      = 12'h341,
        ADDR_MCAUSE    = 12'h342,
        ADDR_MIP       = 12'h344,
        ADDR_MVENDORID = 12'hf11
    } csr_addr_e;

    // Low two bits of mtvec
    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'b00,
        TVEC_VECTORED = 2'b01
    } tvec_mode_e;

    typedef enum logic [1:0] {
        ACT_NONE   = 2'd0,
        ACT_WRITE  = 2'd1,
        ACT_TRAP   = 2'd2,
        ACT_RETURN = 2'd3
    } csr_action_e;

    typedef struct packed {
        csr_cmd_e                cmd;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_XLEN-1:0]    operand;
        logic [`CSR_XLEN-1:0]    pc;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]    rdata;
        logic                    redirect;
        logic                    trap;
        logic [`CSR_XLEN-1:0]    target;
    } csr_rsp_t;

    // Bit 31 of cause marks an interrupt
    typedef struct packed {
        logic [`CSR_XLEN-1:0]    cause;
        logic [`CSR_XLEN-1:0]    epc;
    } trap_info_t;

    typedef struct packed {
        priv_mode_e              mode;
        logic                    mstatus_mie;
        logic                    mie_meie;
        logic                    mie_msie;
        logic                    mie_mtie;
        logic                    mip_meip;
        logic                    mip_msip;
        logic                    mip_mtip;
        logic [`CSR_XLEN-1:0]    mtvec;
        logic [`CSR_XLEN-1:0]    mepc;
    } csr_state_t;

endpackage

/* src/csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`CSR_ADDR_W-1:0]  addr_i,
    input  logic [`CSR_XLEN-1:0]    wdata_i,
    input  csr_action_e             action_i,
    input  trap_info_t              trap_i,
    input  logic [`CSR_TIME_W-1:0]  mtime_i,
    input  logic [`CSR_TIME_W-1:0]  mtimecmp_i,
    input  logic                    msip_i,
    input  logic                    meip_i,
    output logic [`CSR_XLEN-1:0]    rdata_o,
    output csr_state_t              state_o
);

    priv_mode_e           mode;
    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    priv_mode_e           mstatus_mpp;
    logic                 mie_meie;
    logic                 mie_msie;
    logic                 mie_mtie;
    logic                 mip_meip;
    logic                 mip_msip;
    logic                 mip_mtip;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;

    logic [`CSR_XLEN-1:0] mstatus_word;
    logic [`CSR_XLEN-1:0] mie_word;
    logic [`CSR_XLEN-1:0] mip_word;

    // Only MIE, MPIE and MPP exist, the rest reads as zero
    assign mstatus_word = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

    always_comb begin
        mie_word = '0;
        mie_word[`IRQ_MEI] = mie_meie;
        mie_word[`IRQ_MSI] = mie_msie;
        mie_word[`IRQ_MTI] = mie_mtie;
        mip_word = '0;
        mip_word[`IRQ_MEI] = mip_meip;
        mip_word[`IRQ_MSI] = mip_msip;
        mip_word[`IRQ_MTI] = mip_mtip;
    end

    always_comb begin
        case (addr_i)
            ADDR_MSTATUS:   rdata_o = mstatus_word;
            ADDR_MISA:      rdata_o = `MISA_VALUE;
            ADDR_MIE:       rdata_o = mie_word;
            ADDR_MTVEC:     rdata_o = mtvec;
            ADDR_MSCRATCH:  rdata_o = mscratch;
            ADDR_MEPC:      rdata_o = mepc;
            ADDR_MCAUSE:    rdata_o = mcause;
            ADDR_MIP:       rdata_o = mip_word;
            ADDR_MVENDORID: rdata_o = '0;
            default:        rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mode         <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_meie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mip_meip     <= 1'b0;
            mip_msip     <= 1'b0;
            mip_mtip     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            // Pending bits mirror the interrupt sources
            mip_meip <= meip_i;
            mip_msip <= msip_i;
            mip_mtip <= mtime_i >= mtimecmp_i;

            case (action_i)
                ACT_WRITE: begin
                    case (addr_i)
                        ADDR_MSTATUS: begin
                            // MPP only holds U or M
                            mstatus_mpp  <= (wdata_i[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                            mstatus_mpie <= wdata_i[7];
                            mstatus_mie  <= wdata_i[3];
                        end
                        ADDR_MIE: begin
                            mie_meie <= wdata_i[`IRQ_MEI];
                            mie_msie <= wdata_i[`IRQ_MSI];
                            mie_mtie <= wdata_i[`IRQ_MTI];
                        end
                        // Mode bit 1 is dropped so only DIRECT and VECTORED remain
                        ADDR_MTVEC:    mtvec    <= {wdata_i[31:2], 1'b0, wdata_i[0]};
                        ADDR_MSCRATCH: mscratch <= wdata_i;
                        ADDR_MEPC:     mepc     <= {wdata_i[31:2], 2'b00};
                        ADDR_MCAUSE:   mcause   <= wdata_i;
                        default: begin
                        end
                    endcase
                end
                ACT_TRAP: begin
                    mepc         <= trap_i.epc;
                    mcause       <= trap_i.cause;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= mode;
                    mode         <= PRIV_M;
                end
                ACT_RETURN: begin
                    mstatus_mie  <= mstatus_mpie;
                    mode         <= mstatus_mpp;
                    mstatus_mpie <= 1'b1;
                    mstatus_mpp  <= PRIV_U;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        state_o.mode        = mode;
        state_o.mstatus_mie = mstatus_mie;
        state_o.mie_meie    = mie_meie;
        state_o.mie_msie    = mie_msie;
        state_o.mie_mtie    = mie_mtie;
        state_o.mip_meip    = mip_meip;
        state_o.mip_msip    = mip_msip;
        state_o.mip_mtip    = mip_mtip;
        state_o.mtvec       = mtvec;
        state_o.mepc        = mepc;
    end

    // Traps and returns must never leave the core in an unimplemented mode
    a_mode_legal: assert property (@(posedge clk) disable iff (reset_i)
        mode inside {PRIV_U, PRIV_M})
        else $error("privilege mode left U/M");

endmodule

/* src/csr_unit_top.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit_top
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    req_valid_i,
    input  csr_req_t                req_i,
    input  logic [`CSR_TIME_W-1:0]  mtime_i,
    input  logic [`CSR_TIME_W-1:0]  mtimecmp_i,
    input  logic                    msip_i,
    input  logic                    meip_i,
    output logic                    rsp_valid_o,
    output csr_rsp_t                rsp_o,
    output priv_mode_e              priv_o
);

    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] wdata;
    logic                 illegal;
    csr_state_t           state;
    csr_action_e          action;
    trap_info_t           trap_info;

    csr_access_check u_access (
        .cmd_i     (req_i.cmd),
        .addr_i    (req_i.addr),
        .operand_i (req_i.operand),
        .rdata_i   (rdata),
        .mode_i    (state.mode),
        .illegal_o (illegal),
        .wdata_o   (wdata)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .addr_i     (req_i.addr),
        .wdata_i    (wdata),
        .action_i   (action),
        .trap_i     (trap_info),
        .mtime_i    (mtime_i),
        .mtimecmp_i (mtimecmp_i),
        .msip_i     (msip_i),
        .meip_i     (meip_i),
        .rdata_o    (rdata),
        .state_o    (state)
    );

    trap_control u_trap (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .illegal_i   (illegal),
        .rdata_i     (rdata),
        .state_i     (state),
        .action_o    (action),
        .trap_o      (trap_info),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    assign priv_o = state.mode;

endmodule

/* src/trap_control.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module trap_control
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  csr_req_t             req_i,
    input  logic                 illegal_i,
    input  logic [`CSR_XLEN-1:0] rdata_i,
    input  csr_state_t           state_i,
    output csr_action_e          action_o,
    output trap_info_t           trap_o,
    output logic                 rsp_valid_o,
    output csr_rsp_t             rsp_o
);

    logic                 raise_expt;
    logic                 raise_intr;
    logic                 take_trap;
    logic                 global_en;
    logic                 pend_mei;
    logic                 pend_msi;
    logic                 pend_mti;
    logic [`CSR_XLEN-1:0] expt_code;
    logic [`CSR_XLEN-1:0] intr_code;
    logic [`CSR_XLEN-1:0] tvec_base;
    logic [`CSR_XLEN-1:0] trap_target;
    csr_rsp_t             rsp_d;

    assign raise_expt = req_valid_i && (illegal_i || req_i.cmd == CMD_ECALL);

    always_comb begin
        if (illegal_i) begin
            expt_code = `CAUSE_ILLEGAL_INSTR;
        end else if (state_i.mode == PRIV_M) begin
            expt_code = `CAUSE_ECALL_M;
        end else begin
            expt_code = `CAUSE_ECALL_U;
        end
    end

    assign pend_mei  = state_i.mip_meip && state_i.mie_meie;
    assign pend_msi  = state_i.mip_msip && state_i.mie_msie;
    assign pend_mti  = state_i.mip_mtip && state_i.mie_mtie;
    // U-mode can always be preempted by M-level interrupts
    assign global_en = (state_i.mode == PRIV_U) || state_i.mstatus_mie;

    // Exceptions win; the interrupted request is dropped
    assign raise_intr = req_valid_i && !raise_expt && global_en &&
                        (pend_mei || pend_msi || pend_mti);
    assign take_trap  = raise_expt || raise_intr;

    // Fixed priority MEI > MSI > MTI
    always_comb begin
        if (pend_mei) begin
            intr_code = `IRQ_MEI;
        end else if (pend_msi) begin
            intr_code = `IRQ_MSI;
        end else begin
            intr_code = `IRQ_MTI;
        end
    end

    // Vectoring only applies to interrupts
    assign tvec_base   = {state_i.mtvec[31:2], 2'b00};
    assign trap_target = (raise_intr && tvec_mode_e'(state_i.mtvec[1:0]) == TVEC_VECTORED)
                         ? tvec_base + {intr_code[29:0], 2'b00} : tvec_base;

    assign trap_o.cause = raise_intr ? {1'b1, intr_code[30:0]} : expt_code;
    assign trap_o.epc   = req_i.pc;

    always_comb begin
        if (!req_valid_i) begin
            action_o = ACT_NONE;
        end else if (take_trap) begin
            action_o = ACT_TRAP;
        end else if (req_i.cmd == CMD_MRET) begin
            action_o = ACT_RETURN;
        end else if (req_i.cmd inside {CMD_W, CMD_S, CMD_C}) begin
            action_o = ACT_WRITE;
        end else begin
            action_o = ACT_NONE;
        end
    end

    always_comb begin
        rsp_d       = '0;
        rsp_d.rdata = rdata_i;
        if (take_trap) begin
            rsp_d.redirect = 1'b1;
            rsp_d.trap     = 1'b1;
            rsp_d.target   = trap_target;
        end else if (req_i.cmd == CMD_MRET) begin
            rsp_d.redirect = 1'b1;
            rsp_d.target   = state_i.mepc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_o <= rsp_d;
        end
    end

    // Idle cycles must leave the register file untouched
    a_idle_no_action: assert property (@(posedge clk) disable iff (reset_i)
        !req_valid_i |-> action_o == ACT_NONE)
        else $error("action issued without a request");

    a_trap_redirects: assert property (@(posedge clk) disable iff (reset_i)
        rsp_valid_o && rsp_o.trap |-> rsp_o.redirect)
        else $error("trap response without redirect");

endmodule

/* verification/csr_unit_tb.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    logic                   clk;
    logic                   reset_i;
    logic                   req_valid_i;
    csr_req_t               req_i;
    logic [`CSR_TIME_W-1:0] mtime_i;
    logic [`CSR_TIME_W-1:0] mtimecmp_i;
    logic                   msip_i;
    logic                   meip_i;
    logic                   rsp_valid_o;
    csr_rsp_t               rsp_o;
    priv_mode_e             priv_o;

    // Expected machine state, updated when a request is driven
    priv_mode_e           m_mode;
    logic                 m_status_mie;
    logic                 m_mpie;
    priv_mode_e           m_mpp;
    logic [`CSR_XLEN-1:0] m_mie_en;
    logic [`CSR_XLEN-1:0] m_mtvec;
    logic [`CSR_XLEN-1:0] m_mscratch;
    logic [`CSR_XLEN-1:0] m_mepc;
    logic [`CSR_XLEN-1:0] m_mcause;

    csr_rsp_t             exp_rsp;
    csr_rsp_t             exp_rsp_q;
    priv_mode_e           exp_mode_q;
    int                   err_count;
    int                   err_at_start;
    int                   tests_passed;
    int                   tests_failed;
    logic [`CSR_XLEN-1:0] base;

    csr_unit_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expectations line up with the edge that samples the request
    always @(posedge clk) begin
        exp_rsp_q  <= exp_rsp;
        exp_mode_q <= m_mode;
    end

    a_rsp_match: assert property (@(posedge clk) disable iff (reset_i)
        req_valid_i |=> rsp_valid_o && rsp_o == exp_rsp_q)
        else begin
            err_count++;
            $display("error %0t: response got %h expected %h", $time,
                     $sampled(rsp_o), $sampled(exp_rsp_q));
        end

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !req_valid_i |=> !rsp_valid_o)
        else begin
            err_count++;
            $display("error %0t: response strobe without a request", $time);
        end

    a_mode_match: assert property (@(posedge clk) disable iff (reset_i)
        priv_o == exp_mode_q)
        else begin
            err_count++;
            $display("error %0t: mode got %0d expected %0d", $time,
                     $sampled(priv_o), $sampled(exp_mode_q));
        end

    function automatic logic [`CSR_XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] addr);
        logic [`CSR_XLEN-1:0] word;
        word = '0;
        case (addr)
            ADDR_MSTATUS: begin
                word[12:11] = m_mpp;
                word[7]     = m_mpie;
                word[3]     = m_status_mie;
            end
            ADDR_MISA:     word = `MISA_VALUE;
            ADDR_MIE:      word = m_mie_en;
            ADDR_MTVEC:    word = m_mtvec;
            ADDR_MSCRATCH: word = m_mscratch;
            ADDR_MEPC:     word = m_mepc;
            ADDR_MCAUSE:   word = m_mcause;
            default:       word = '0;
        endcase
        return word;
    endfunction

    // Predicts the response, updates the model, then drives one strobe
    task automatic issue(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                         input logic [`CSR_XLEN-1:0] operand, input logic [`CSR_XLEN-1:0] pc);
        logic [`CSR_XLEN-1:0] rd;
        logic [`CSR_XLEN-1:0] wd;
        logic [`CSR_XLEN-1:0] code;
        logic                 is_csr;
        logic                 illegal;
        logic                 irq;
        csr_rsp_t             rsp;
        is_csr  = cmd == CMD_W || cmd == CMD_S || cmd == CMD_C;
        rd      = model_read(addr);
        illegal = (is_csr && (addr[9:8] > m_mode || addr[11:10] == 2'b11)) ||
                  (cmd == CMD_MRET && m_mode != PRIV_M);
        irq     = 1'b0;
        code    = '0;
        if (illegal) begin
            code = `CAUSE_ILLEGAL_INSTR;
        end else if (cmd == CMD_ECALL) begin
            code = (m_mode == PRIV_M) ? `CAUSE_ECALL_M : `CAUSE_ECALL_U;
        end else if (m_mode == PRIV_U || m_status_mie) begin
            if (meip_i && m_mie_en[`IRQ_MEI]) begin
                code = `IRQ_MEI;
            end else if (msip_i && m_mie_en[`IRQ_MSI]) begin
                code = `IRQ_MSI;
            end else if (mtime_i >= mtimecmp_i && m_mie_en[`IRQ_MTI]) begin
                code = `IRQ_MTI;
            end
            irq = code != 0;
        end
        rsp       = '0;
        rsp.rdata = rd;
        if (illegal || cmd == CMD_ECALL || irq) begin
            rsp.redirect = 1'b1;
            rsp.trap     = 1'b1;
            rsp.target   = {m_mtvec[31:2], 2'b00};
            if (irq && m_mtvec[1:0] == TVEC_VECTORED) begin
                rsp.target = rsp.target + 4 * code;
            end
            m_mepc       = pc;
            m_mcause     = irq ? (32'h8000_0000 | code) : code;
            m_mpie       = m_status_mie;
            m_status_mie = 1'b0;
            m_mpp        = m_mode;
            m_mode       = PRIV_M;
        end else if (cmd == CMD_MRET) begin
            rsp.redirect = 1'b1;
            rsp.target   = m_mepc;
            m_status_mie = m_mpie;
            m_mode       = m_mpp;
            m_mpie       = 1'b1;
            m_mpp        = PRIV_U;
        end else if (is_csr) begin
            case (cmd)
                CMD_W:   wd = operand;
                CMD_S:   wd = rd | operand;
                default: wd = rd & ~operand;
            endcase
            case (addr)
                ADDR_MSTATUS: begin
                    m_status_mie = wd[3];
                    m_mpie       = wd[7];
                    m_mpp        = (wd[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                end
                ADDR_MIE: begin
                    m_mie_en = '0;
                    m_mie_en[`IRQ_MEI] = wd[`IRQ_MEI];
                    m_mie_en[`IRQ_MSI] = wd[`IRQ_MSI];
                    m_mie_en[`IRQ_MTI] = wd[`IRQ_MTI];
                end
                ADDR_MTVEC:    m_mtvec    = wd;
                ADDR_MSCRATCH: m_mscratch = wd;
                ADDR_MEPC:     m_mepc     = {wd[31:2], 2'b00};
                ADDR_MCAUSE:   m_mcause   = wd;
                default: begin
                end
            endcase
        end
        exp_rsp       = rsp;
        req_i.cmd     = cmd;
        req_i.addr    = addr;
        req_i.operand = operand;
        req_i.pc      = pc;
        req_valid_i   = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic await_response();
        int waited;
        req_valid_i = 1'b0;
        waited = 0;
        while (!rsp_valid_o && waited < 10) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!rsp_valid_o) begin
            err_count++;
            $display("timeout: no response strobe for the last request at %0t", $time);
        end
        // One more edge so the response check has run
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        req_valid_i = 1'b0;
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    task automatic close_test(input string name);
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - err_at_start);
        end
        err_at_start = err_count;
    endtask

    initial begin
        void'($urandom(32'hceb70e17));
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        mtime_i      = '0;
        mtimecmp_i   = '1;
        msip_i       = 1'b0;
        meip_i       = 1'b0;
        m_mode       = PRIV_M;
        m_status_mie = 1'b0;
        m_mpie       = 1'b0;
        m_mpp        = PRIV_U;
        m_mie_en     = '0;
        m_mtvec      = '0;
        m_mscratch   = '0;
        m_mepc       = '0;
        m_mcause     = '0;
        exp_rsp      = '0;
        err_count    = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;

        idle(3);
        issue(CMD_NONE, ADDR_MSTATUS, '0, '0);
        await_response();
        close_test("reset_state");

        issue(CMD_W, ADDR_MSCRATCH, $urandom, '0);
        issue(CMD_S, ADDR_MSCRATCH, $urandom, '0);
        issue(CMD_C, ADDR_MSCRATCH, $urandom, '0);
        issue(CMD_NONE, ADDR_MSCRATCH, '0, '0);
        issue(CMD_NONE, ADDR_MISA, '0, '0);
        await_response();
        close_test("read_modify_write");

        base = $urandom & 32'hffff_ff00;
        issue(CMD_W, ADDR_MTVEC, base, '0);
        issue(CMD_W, ADDR_MVENDORID, $urandom, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        issue(CMD_NONE, ADDR_MEPC, '0, '0);
        await_response();
        close_test("illegal_access");

        // M-mode ECALL, drop to U through MRET, then fault and call back up
        issue(CMD_ECALL, '0, '0, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        issue(CMD_W, ADDR_MSTATUS, '0, '0);
        issue(CMD_W, ADDR_MEPC, $urandom & 32'hffff_fffc, '0);
        issue(CMD_MRET, '0, '0, '0);
        issue(CMD_S, ADDR_MSCRATCH, '0, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        issue(CMD_MRET, '0, '0, '0);
        issue(CMD_ECALL, '0, '0, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        await_response();
        close_test("ecall_mret");

        base = $urandom & 32'hffff_ff00;
        issue(CMD_W, ADDR_MTVEC, base | 32'h1, '0);
        issue(CMD_W, ADDR_MIE, 32'h1 << `IRQ_MTI, '0);
        await_response();
        mtimecmp_i = 64'h0000_0001_0000_0000;
        mtime_i    = mtimecmp_i + $urandom;
        idle(2);
        issue(CMD_W, ADDR_MSTATUS, 32'h8, '0);
        issue(CMD_W, ADDR_MSCRATCH, $urandom, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        issue(CMD_NONE, ADDR_MEPC, '0, '0);
        issue(CMD_NONE, ADDR_MSCRATCH, '0, '0);
        await_response();
        close_test("timer_interrupt_vectored");

        // Timer still due, external interrupt must win
        meip_i = 1'b1;
        issue(CMD_W, ADDR_MIE, (32'h1 << `IRQ_MEI) | (32'h1 << `IRQ_MTI), '0);
        await_response();
        issue(CMD_W, ADDR_MSTATUS, 32'h8, '0);
        issue(CMD_W, ADDR_MSCRATCH, $urandom, $urandom & 32'hffff_fffc);
        issue(CMD_NONE, ADDR_MCAUSE, '0, '0);
        await_response();
        close_test("interrupt_priority");

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
